// File: Makefile
# Verilator simulation of the accelerator command front end

VERILATOR ?= verilator
TOP       ?= tb_accel_cmd
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a missing pass line fails the target
run: compile
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
src/cmd_pkg.sv
src/status_pkg.sv
src/cmd_queue.sv
src/cmd_intake.sv
src/completion_tracker.sv
src/accel_cmd_top.sv
testbench/tb_accel_cmd.sv

// File: src/accel_cmd_top.sv
// Accelerator command front end
// Intake, paired queues and completion tracking
`default_nettype none

module accel_cmd_top
#(
  parameter int DEPTH = 8
)
(
  input  wire                     rvx_port_25,
  input  wire                     rvx_port_15,
  input  wire                     i_push,
  input  cmd_pkg::cmd_entry_t     i_cmd,
  input  wire                     i_inst_take,
  input  wire                     i_done,
  input  wire                     i_itr_clear,
  input  cmd_pkg::itr_mask_t      i_itr_clear_mask,
  output logic                    o_inst_valid,
  output cmd_pkg::inst_t          o_inst,
  output status_pkg::cmd_status_t o_status,
  output cmd_pkg::itr_mask_t      o_pending,
  output logic                    o_irq
);

  import cmd_pkg::*;
  import status_pkg::*;

  logic             wr;
  cmd_entry_t       entry;
  logic             overflow;
  logic [CNT_W-1:0] outstanding;
  logic             mask_pop;
  itr_mask_t        head_mask;

  // ************************************************************
  // Intake
  // ************************************************************

  cmd_intake
  #(
    .DEPTH(DEPTH)
  )
  u_intake
  (
    .rvx_port_25  (rvx_port_25),
    .rvx_port_15  (rvx_port_15),
    .i_push       (i_push),
    .i_cmd        (i_cmd),
    .i_outstanding(outstanding),
    .o_wr         (wr),
    .o_entry      (entry),
    .o_overflow   (overflow)
  );

  // ************************************************************
  // Queues, written on the same edge
  // ************************************************************

  // Instruction words, popped by the accelerator
  cmd_queue
  #(
    .T_ENTRY(inst_t),
    .DEPTH  (DEPTH)
  )
  u_inst_queue
  (
    .rvx_port_25(rvx_port_25),
    .rvx_port_15(rvx_port_15),
    .i_wr       (wr),
    .i_wdata    (entry.inst),
    .i_rd       (i_inst_take),
    .o_rdata    (o_inst),
    .o_valid    (o_inst_valid),
    .o_full     ()
  );

  // Interrupt masks, popped on completion
  cmd_queue
  #(
    .T_ENTRY(itr_mask_t),
    .DEPTH  (DEPTH)
  )
  u_itr_queue
  (
    .rvx_port_25(rvx_port_25),
    .rvx_port_15(rvx_port_15),
    .i_wr       (wr),
    .i_wdata    (entry.mask),
    .i_rd       (mask_pop),
    .o_rdata    (head_mask),
    .o_valid    (),
    .o_full     ()
  );

  // ************************************************************
  // Completion tracking
  // ************************************************************

  completion_tracker
  #(
    .DEPTH(DEPTH)
  )
  u_tracker
  (
    .rvx_port_25     (rvx_port_25),
    .rvx_port_15     (rvx_port_15),
    .i_wr            (wr),
    .i_done          (i_done),
    .i_head_mask     (head_mask),
    .i_itr_clear     (i_itr_clear),
    .i_itr_clear_mask(i_itr_clear_mask),
    .i_overflow      (overflow),
    .o_mask_pop      (mask_pop),
    .o_outstanding   (outstanding),
    .o_status        (o_status),
    .o_pending       (o_pending),
    .o_irq           (o_irq)
  );

endmodule

`default_nettype wire

// File: src/cmd_intake.sv
// Command admission stage
`default_nettype none

module cmd_intake
#(
  parameter int DEPTH = 8
)
(
  input  wire                          rvx_port_25,
  input  wire                          rvx_port_15,
  input  wire                          i_push,
  input  cmd_pkg::cmd_entry_t          i_cmd,
  input  wire [status_pkg::CNT_W-1:0]  i_outstanding,
  output logic                         o_wr,
  output cmd_pkg::cmd_entry_t          o_entry,
  output logic                         o_overflow
);

  import status_pkg::*;

  // One extra bit so the sum with the in-flight entry cannot wrap
  typedef logic [CNT_W:0] cnt_ext_t;

  localparam cnt_ext_t LIMIT = cnt_ext_t'(DEPTH);

  cnt_ext_t committed;
  logic     accept;

  // ************************************************************
  // Admission
  // ************************************************************

  // The registered entry is not yet in the count
  assign committed = cnt_ext_t'(i_outstanding) + cnt_ext_t'(o_wr);
  assign accept    = i_push && (committed < LIMIT);

  // One-cycle write strobe towards both queues
  always_ff @(posedge rvx_port_25 or negedge rvx_port_15)
  begin
    if (!rvx_port_15)
    begin
      o_wr <= 1'b0;
    end
    else
    begin
      o_wr <= accept;
    end
  end

  always_ff @(posedge rvx_port_25)
  begin
    if (accept)
    begin
      o_entry <= i_cmd;
    end
  end

  // Refused push is dropped and the flag holds until reset
  always_ff @(posedge rvx_port_25 or negedge rvx_port_15)
  begin
    if (!rvx_port_15)
    begin
      o_overflow <= 1'b0;
    end
    else if (i_push && !accept)
    begin
      o_overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/cmd_pkg.sv
// Instruction payload types
`default_nettype none

package cmd_pkg;

  // ************************************************************
  // Sizing
  // ************************************************************

  // Instruction word width
  localparam int INST_W = 32;

  // One bit per interrupt line
  localparam int ITR_W = 8;

  // ************************************************************
  // Payload types
  // ************************************************************

  typedef logic [INST_W-1:0] inst_t;

  // Lines raised when the instruction completes
  typedef logic [ITR_W-1:0] itr_mask_t;

  // Host command, 40 bits
  typedef struct packed {
    inst_t     inst;
    itr_mask_t mask;
  } cmd_entry_t;

endpackage

`default_nettype wire

// File: src/cmd_queue.sv
// Show-ahead synchronous FIFO
`default_nettype none

module cmd_queue
#(
  parameter type T_ENTRY = logic [7:0],
  parameter int  DEPTH   = 8
)
(
  input  wire    rvx_port_25,
  input  wire    rvx_port_15,
  input  wire    i_wr,
  input  T_ENTRY i_wdata,
  input  wire    i_rd,
  output T_ENTRY o_rdata,
  output logic   o_valid,
  output logic   o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [OCC_W-1:0] FULL_OCC = OCC_W'(DEPTH);

  T_ENTRY           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occ;
  logic             wr_en;
  logic             rd_en;

  assign o_full  = (occ == FULL_OCC);
  assign o_valid = (occ != '0);

  assign wr_en = i_wr && !o_full;
  assign rd_en = i_rd && o_valid;

  // ************************************************************
  // Storage and pointers
  // ************************************************************

  always_ff @(posedge rvx_port_25)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  // Pointers wrap at DEPTH, so any depth works
  always_ff @(posedge rvx_port_25 or negedge rvx_port_15)
  begin
    if (!rvx_port_15)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge rvx_port_25 or negedge rvx_port_15)
  begin
    if (!rvx_port_15)
    begin
      occ <= '0;
    end
    else if (wr_en && !rd_en)
    begin
      occ <= occ + 1'b1;
    end
    else if (rd_en && !wr_en)
    begin
      occ <= occ - 1'b1;
    end
  end

  // Head entry shown ahead of the pop
  assign o_rdata = mem[rd_ptr];

  // ************************************************************
  // Checks
  // ************************************************************

  a_no_write_when_full: assert property (
    @(posedge rvx_port_25) disable iff (!rvx_port_15) !(i_wr && o_full)
  ) else $error("cmd_queue: write while full");

  a_no_read_when_empty: assert property (
    @(posedge rvx_port_25) disable iff (!rvx_port_15) !(i_rd && !o_valid)
  ) else $error("cmd_queue: read while empty");

endmodule

`default_nettype wire

// File: src/completion_tracker.sv
// Outstanding count and pending interrupts
`default_nettype none

module completion_tracker
#(
  parameter int DEPTH = 8
)
(
  input  wire                          rvx_port_25,
  input  wire                          rvx_port_15,
  input  wire                          i_wr,
  input  wire                          i_done,
  input  cmd_pkg::itr_mask_t           i_head_mask,
  input  wire                          i_itr_clear,
  input  cmd_pkg::itr_mask_t           i_itr_clear_mask,
  input  wire                          i_overflow,
  output logic                         o_mask_pop,
  output logic [status_pkg::CNT_W-1:0] o_outstanding,
  output status_pkg::cmd_status_t      o_status,
  output cmd_pkg::itr_mask_t           o_pending,
  output logic                         o_irq
);

  import cmd_pkg::*;
  import status_pkg::*;

  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(DEPTH);

  logic [CNT_W-1:0] outstanding;
  itr_mask_t        pending;
  itr_mask_t        pending_nxt;

  // ************************************************************
  // Outstanding counter
  // ************************************************************

  // Write and completion together leave the count unchanged
  always_ff @(posedge rvx_port_25 or negedge rvx_port_15)
  begin
    if (!rvx_port_15)
    begin
      outstanding <= '0;
    end
    else
    begin
      case ({i_wr, i_done})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  assign o_outstanding = outstanding;

  assign o_status.outstanding = outstanding;
  assign o_status.free        = LIMIT - outstanding;
  assign o_status.overflow    = i_overflow;

  // ************************************************************
  // Pending interrupts
  // ************************************************************

  // Head of the mask queue belongs to the oldest taken instruction
  assign o_mask_pop = i_done;

  // Merge first, then clear, so a clear in the same cycle wins
  always_comb
  begin
    pending_nxt = pending;
    if (i_done)
    begin
      pending_nxt = pending_nxt | i_head_mask;
    end
    if (i_itr_clear)
    begin
      pending_nxt = pending_nxt & ~i_itr_clear_mask;
    end
  end

  always_ff @(posedge rvx_port_25 or negedge rvx_port_15)
  begin
    if (!rvx_port_15)
    begin
      pending <= '0;
    end
    else
    begin
      pending <= pending_nxt;
    end
  end

  assign o_pending = pending;
  assign o_irq     = |pending;

  // Completion needs an accepted instruction behind it
  a_done_needs_outstanding: assert property (
    @(posedge rvx_port_25) disable iff (!rvx_port_15) i_done |-> (outstanding != '0)
  ) else $error("completion_tracker: done with nothing outstanding");

  a_outstanding_bounded: assert property (
    @(posedge rvx_port_25) disable iff (!rvx_port_15) outstanding <= LIMIT
  ) else $error("completion_tracker: outstanding above limit");

endmodule

`default_nettype wire

// File: src/status_pkg.sv
// Host status types
`default_nettype none

package status_pkg;

  // Width of each count field
  localparam int CNT_W = 8;

  // ************************************************************
  // Status word seen by the host, 17 bits
  // ************************************************************

  typedef struct packed {
    // Accepted but not yet completed
    logic [CNT_W-1:0] outstanding;
    // Slots left below the limit
    logic [CNT_W-1:0] free;
    // Sticky, set by a dropped push
    logic             overflow;
  } cmd_status_t;

endpackage

`default_nettype wire

// File: testbench/tb_accel_cmd.sv
// Testbench for the accelerator command front end
`default_nettype none

module tb_accel_cmd;

  timeunit 1ns;
  timeprecision 100ps;

  import cmd_pkg::*;
  import status_pkg::*;

  localparam int DEPTH        = 8;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_STEPS = 80;

  typedef struct {
    string       test;
    logic        push;
    cmd_entry_t  cmd;
    logic        take;
    logic        done;
    logic        clear;
    itr_mask_t   clear_mask;
    cmd_status_t exp_status;
    itr_mask_t   exp_pending;
    logic        exp_valid;
    inst_t       exp_inst;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic        host_push;
  cmd_entry_t  host_cmd;
  logic        inst_take;
  logic        inst_done;
  logic        itr_clear;
  itr_mask_t   itr_clear_mask;
  logic        inst_valid;
  inst_t       inst;
  cmd_status_t status;
  itr_mask_t   pending;
  logic        irq;

  step_t       steps[$];
  logic        table_ready;
  int          error_count;
  int          check_count;
  int          timeout_cycles;
  logic [15:0] lfsr;

  // Expected state, stepped by the rules of the front end
  inst_t       ref_inst_q[$];
  itr_mask_t   ref_mask_q[$];
  int          ref_outstanding;
  int          ref_taken;
  logic        ref_inflight;
  itr_mask_t   ref_pending;
  logic        ref_overflow;

  accel_cmd_top #(.DEPTH(DEPTH)) UUT
  (
    .rvx_port_25     (clk),
    .rvx_port_15     (rst_n),
    .i_push          (host_push),
    .i_cmd           (host_cmd),
    .i_inst_take     (inst_take),
    .i_done          (inst_done),
    .i_itr_clear     (itr_clear),
    .i_itr_clear_mask(itr_clear_mask),
    .o_inst_valid    (inst_valid),
    .o_inst          (inst),
    .o_status        (status),
    .o_pending       (pending),
    .o_irq           (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ************************************************************
  // Random source and expected values
  // ************************************************************

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
    return value;
  endfunction

  function automatic cmd_entry_t random_cmd();
    cmd_entry_t c;
    c.inst = random_bits(INST_W);
    c.mask = itr_mask_t'(random_bits(ITR_W));
    return c;
  endfunction

  // State after the edge that samples this step's inputs
  task automatic add_step(input string test, input logic push, input cmd_entry_t cmd,
                          input logic take, input logic done,
                          input logic clear, input itr_mask_t clear_mask);
    step_t s;
    logic  accept;
    s.test       = test;
    s.push       = push;
    s.cmd        = cmd;
    s.take       = take;
    s.done       = done;
    s.clear      = clear;
    s.clear_mask = clear_mask;
    // The entry still waiting for its write strobe counts against the limit
    accept = push && ((ref_outstanding + int'(ref_inflight)) < DEPTH);
    if (push && !accept)
    begin
      ref_overflow = 1'b1;
    end
    if (take)
    begin
      void'(ref_inst_q.pop_front());
      ref_taken++;
    end
    if (done)
    begin
      ref_pending = ref_pending | ref_mask_q.pop_front();
      ref_outstanding--;
      ref_taken--;
    end
    if (clear)
    begin
      ref_pending = ref_pending & ~clear_mask;
    end
    if (ref_inflight)
    begin
      ref_inst_q.push_back(steps[steps.size() - 1].cmd.inst);
      ref_mask_q.push_back(steps[steps.size() - 1].cmd.mask);
      ref_outstanding++;
    end
    ref_inflight = accept;
    s.exp_status.outstanding = CNT_W'(ref_outstanding);
    s.exp_status.free        = CNT_W'(DEPTH - ref_outstanding);
    s.exp_status.overflow    = ref_overflow;
    s.exp_pending            = ref_pending;
    s.exp_valid              = (ref_inst_q.size() != 0);
    s.exp_inst               = s.exp_valid ? ref_inst_q[0] : '0;
    steps.push_back(s);
  endtask

  task automatic add_idle(input string test, input int n);
    for (int i = 0; i < n; i++)
    begin
      add_step(test, 1'b0, '0, 1'b0, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic build_table();
    cmd_entry_t c;
    itr_mask_t  m;
    logic       push;
    logic       take;
    logic       done;
    logic       clear;
    add_idle("reset", 2);
    for (int i = 0; i < 3; i++)
    begin
      add_step("order", 1'b1, random_cmd(), 1'b0, 1'b0, 1'b0, '0);
    end
    add_idle("order", 2);
    for (int i = 0; i < 3; i++)
    begin
      add_step("order", 1'b0, '0, 1'b1, 1'b0, 1'b0, '0);
    end
    for (int i = 0; i < 3; i++)
    begin
      add_step("order", 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
    end
    add_step("order", 1'b0, '0, 1'b0, 1'b0, 1'b1, 8'hFF);
    // One push past the limit, then another after the queue settles
    for (int i = 0; i <= DEPTH; i++)
    begin
      add_step("limit", 1'b1, random_cmd(), 1'b0, 1'b0, 1'b0, '0);
    end
    add_idle("limit", 2);
    add_step("limit", 1'b1, random_cmd(), 1'b0, 1'b0, 1'b0, '0);
    for (int i = 0; i < DEPTH; i++)
    begin
      add_step("limit", 1'b0, '0, 1'b1, 1'b0, 1'b0, '0);
    end
    for (int i = 0; i < DEPTH; i++)
    begin
      add_step("completion", 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
    end
    add_step("clear", 1'b0, '0, 1'b0, 1'b0, 1'b1, 8'hF0);
    add_step("clear", 1'b0, '0, 1'b0, 1'b0, 1'b1, 8'hFF);
    c      = random_cmd();
    c.mask = 8'h0F;
    add_step("clear", 1'b1, c, 1'b0, 1'b0, 1'b0, '0);
    c      = random_cmd();
    c.mask = 8'h3C;
    add_step("clear", 1'b1, c, 1'b0, 1'b0, 1'b0, '0);
    add_idle("clear", 2);
    add_step("clear", 1'b0, '0, 1'b1, 1'b0, 1'b0, '0);
    add_step("clear", 1'b0, '0, 1'b1, 1'b1, 1'b0, '0);
    // Bit 2 is merged and cleared on the same edge
    add_step("clear", 1'b0, '0, 1'b0, 1'b1, 1'b1, 8'h24);
    add_step("clear", 1'b0, '0, 1'b0, 1'b0, 1'b1, 8'hFF);
    for (int i = 0; i < RANDOM_STEPS; i++)
    begin
      push  = (random_bits(1) != 0);
      c     = random_cmd();
      take  = (random_bits(1) != 0) && (ref_inst_q.size() != 0);
      done  = (random_bits(1) != 0) && (ref_taken > 0);
      clear = (random_bits(2) == 0);
      m     = itr_mask_t'(random_bits(ITR_W));
      add_step("random", push, c, take, done, clear, m);
    end
    add_idle("random", 2);
  endtask

  // ************************************************************
  // Drive and check
  // ************************************************************

  task automatic apply_inputs(input step_t s);
    host_push      = s.push;
    host_cmd       = s.cmd;
    inst_take      = s.take;
    inst_done      = s.done;
    itr_clear      = s.clear;
    itr_clear_mask = s.clear_mask;
  endtask

  task automatic drive_idle();
    host_push      = 1'b0;
    host_cmd       = '0;
    inst_take      = 1'b0;
    inst_done      = 1'b0;
    itr_clear      = 1'b0;
    itr_clear_mask = '0;
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %s %s expected 0x%0h actual 0x%0h at %0t",
               test, field, expected, actual, $time);
    end
  endtask

  task automatic check_step(input step_t s);
    check_value(s.test, "outstanding", s.exp_status.outstanding, status.outstanding);
    check_value(s.test, "free", s.exp_status.free, status.free);
    check_value(s.test, "overflow", s.exp_status.overflow, status.overflow);
    check_value(s.test, "pending", s.exp_pending, pending);
    check_value(s.test, "irq", (s.exp_pending != '0), irq);
    check_value(s.test, "inst_valid", s.exp_valid, inst_valid);
    if (s.exp_valid)
    begin
      check_value(s.test, "inst", s.exp_inst, inst);
    end
  endtask

  task automatic run_table();
    int test_start;
    int test_errors;
    int test_count;
    test_start  = 0;
    test_errors = error_count;
    test_count  = 0;
    for (int i = 0; i < steps.size(); i++)
    begin
      apply_inputs(steps[i]);
      @(posedge clk);
      #1;
      check_step(steps[i]);
      if ((i == steps.size() - 1) || (steps[i + 1].test != steps[i].test))
      begin
        $display("%-10s %0d steps, %0d mismatches",
                 steps[i].test, i + 1 - test_start, error_count - test_errors);
        test_start  = i + 1;
        test_errors = error_count;
        test_count++;
      end
    end
    drive_idle();
    $display("Summary: %0d tests, %0d checks, %0d mismatches",
             test_count, check_count, error_count);
  endtask

  initial
  begin
    rst_n           = 1'b0;
    drive_idle();
    error_count     = 0;
    check_count     = 0;
    table_ready     = 1'b0;
    lfsr            = 16'd14;
    ref_outstanding = 0;
    ref_taken       = 0;
    ref_inflight    = 1'b0;
    ref_pending     = '0;
    ref_overflow    = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_table();
    if (error_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    wait (table_ready);
    timeout_cycles = steps.size() * 20 + RESET_CYCLES;
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: the table did not finish within %0d cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
